/* hdl/cl_ocl_cfg.svh */
`ifndef CL_OCL_CFG_SVH
`define CL_OCL_CFG_SVH

// ------------------------------
// bus and counter widths
// ------------------------------
`define OCL_ADDR_W     32               // register address
`define OCL_DATA_W     32               // register data
`define OCL_STRB_W     4                // one strobe per byte lane
`define CNT_W          16               // main counter
`define TICK_W         8                // prescaler

// ------------------------------
// identity and fixed words
// ------------------------------
`define CL_ID0         32'hA1C0_7E55    // vendor / device word
`define CL_ID1         32'h0001_0F00    // subsystem word
`define CL_STATUS0     32'h0000_0FF0    // fixed status
`define CL_VERSION     32'hEEEE_EE00    // design version

// ------------------------------
// register map, byte offsets
// ------------------------------
`define REG_ID0        32'h0000_0000
`define REG_ID1        32'h0000_0004
`define REG_STATUS0    32'h0000_0008
`define REG_VERSION    32'h0000_000C
`define REG_CTRL       32'h0000_0010    // bit0 enable, bit1 clear, bit2 oneshot
`define REG_TICK       32'h0000_0014    // prescaler period
`define REG_LOAD       32'h0000_0018    // write loads the count
`define REG_WATERMARK  32'h0000_001C
`define REG_COUNT      32'h0000_0020    // read only
`define REG_FLAGS      32'h0000_0024    // read only, bit0 tick, bit1 ge_watermark

`define RESP_OKAY      2'd0
`define RESP_SLVERR    2'd2

`endif

/* hdl/cl_ocl_pkg.sv */
package cl_ocl_pkg;

  `include "cl_ocl_cfg.svh"

  // ------------------------------
  // register bus payloads
  // ------------------------------

  // aw and ar request
  typedef struct packed {
    logic [`OCL_ADDR_W-1:0] addr;       // byte address, word aligned in use
  } ocl_addr_t;

  // w request
  typedef struct packed {
    logic [`OCL_DATA_W-1:0] data;       // write data
    logic [`OCL_STRB_W-1:0] strb;       // byte enables
  } ocl_wdata_t;

  // b response
  typedef struct packed {
    logic [1:0]             resp;       // okay or slverr
  } ocl_bresp_t;

  // r response
  typedef struct packed {
    logic [`OCL_DATA_W-1:0] data;       // read data, zero on error
    logic [1:0]             resp;       // okay or slverr
  } ocl_rresp_t;

  // ------------------------------
  // counter control and status
  // ------------------------------

  typedef struct packed {
    logic                   enable;     // run prescaler and count
    logic                   clear;      // level, zeroes both counts
    logic                   oneshot;    // saturate instead of wrap
    logic                   load;       // one cycle pulse
    logic [`TICK_W-1:0]     tick_value; // prescaler wraps after this value
    logic [`CNT_W-1:0]      load_value;
    logic [`CNT_W-1:0]      watermark;
  } cnt_ctrl_t;

  typedef struct packed {
    logic [`CNT_W-1:0]      count;
    logic [`TICK_W-1:0]     tick_cnt;
    logic                   tick;       // prescaler wrap seen
    logic                   ge_watermark;
  } cnt_stat_t;

endpackage

/* hdl/axil_reg_slice.sv */
`timescale 1ns/1ps

module axil_reg_slice
  import cl_ocl_pkg::*;
#(
  parameter type payload_t = ocl_addr_t   // request payload carried by the slice
)
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n,

  // upstream side, from host
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,

  // downstream side, to register file
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  // ------------------------------
  // one deep pipeline stage
  // ------------------------------

  // space when empty or the held item leaves this cycle
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      out_valid <= 1'b0;                  // slice empty
    end
    else if (in_ready)
    begin
      out_valid <= in_valid;              // refill or drain
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk_main_a0)
  begin
    if (in_valid && in_ready)
    begin
      out_payload <= in_payload;
    end
  end

endmodule

/* hdl/ocl_reg_file.sv */
`timescale 1ns/1ps

`include "cl_ocl_cfg.svh"

module ocl_reg_file
  import cl_ocl_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n,

  // write request, from slices
  input  logic       aw_valid,
  output logic       aw_ready,
  input  ocl_addr_t  aw_payload,
  input  logic       w_valid,
  output logic       w_ready,
  input  ocl_wdata_t w_payload,

  // write response
  output logic       b_valid,
  input  logic       b_ready,
  output ocl_bresp_t b_payload,

  // read request and response
  input  logic       ar_valid,
  output logic       ar_ready,
  input  ocl_addr_t  ar_payload,
  output logic       r_valid,
  input  logic       r_ready,
  output ocl_rresp_t r_payload,

  // counter side
  output cnt_ctrl_t  cnt_ctrl,
  input  cnt_stat_t  cnt_stat
);

  logic                   wr_take;      // aw and w consumed together
  logic                   rd_take;
  logic [`OCL_ADDR_W-1:0] wr_addr;      // word aligned
  logic [`OCL_ADDR_W-1:0] rd_addr;
  logic                   wr_ctrl;
  logic                   wr_tick;
  logic                   wr_load;
  logic                   wr_wm;
  logic                   wr_ok;        // writable offset
  logic [`OCL_DATA_W-1:0] ctrl_wr;      // strobe merged values
  logic [`OCL_DATA_W-1:0] tick_wr;
  logic [`OCL_DATA_W-1:0] wm_wr;
  logic [`OCL_DATA_W-1:0] rd_data;
  logic                   rd_err;

  // replace only the byte lanes with a strobe set
  function automatic logic [`OCL_DATA_W-1:0] strb_merge(
    input logic [`OCL_DATA_W-1:0] old_val,
    input ocl_wdata_t             wd
  );
    logic [`OCL_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `OCL_STRB_W; i++)
    begin
      if (wd.strb[i])
      begin
        res[8*i +: 8] = wd.data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // handshakes
  // ------------------------------
  assign wr_take  = aw_valid & w_valid & (~b_valid | b_ready);  // response slot free
  assign aw_ready = wr_take;
  assign w_ready  = wr_take;
  assign rd_take  = ar_valid & (~r_valid | r_ready);
  assign ar_ready = rd_take;

  // ------------------------------
  // write decode
  // ------------------------------
  assign wr_addr = {aw_payload.addr[`OCL_ADDR_W-1:2], 2'b00};
  assign rd_addr = {ar_payload.addr[`OCL_ADDR_W-1:2], 2'b00};
  assign wr_ctrl = (wr_addr == `REG_CTRL);
  assign wr_tick = (wr_addr == `REG_TICK);
  assign wr_load = (wr_addr == `REG_LOAD);
  assign wr_wm   = (wr_addr == `REG_WATERMARK);
  assign wr_ok   = wr_ctrl | wr_tick | wr_load | wr_wm;  // id, status, count, flags are ro

  assign ctrl_wr = strb_merge({{(`OCL_DATA_W-3){1'b0}}, cnt_ctrl.oneshot,
                               cnt_ctrl.clear, cnt_ctrl.enable}, w_payload);
  assign tick_wr = strb_merge({{(`OCL_DATA_W-`TICK_W){1'b0}}, cnt_ctrl.tick_value},
                              w_payload);
  assign wm_wr   = strb_merge({{(`OCL_DATA_W-`CNT_W){1'b0}}, cnt_ctrl.watermark},
                              w_payload);

  // control registers
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt_ctrl <= '0;
    end
    else
    begin
      cnt_ctrl.load <= wr_take & wr_load;                 // single cycle pulse
      if (wr_take && wr_ctrl)
      begin
        cnt_ctrl.enable  <= ctrl_wr[0];
        cnt_ctrl.clear   <= ctrl_wr[1];
        cnt_ctrl.oneshot <= ctrl_wr[2];
      end
      if (wr_take && wr_tick)
      begin
        cnt_ctrl.tick_value <= tick_wr[`TICK_W-1:0];
      end
      if (wr_take && wr_load)
      begin
        cnt_ctrl.load_value <= w_payload.data[`CNT_W-1:0];  // no strobe on load
      end
      if (wr_take && wr_wm)
      begin
        cnt_ctrl.watermark <= wm_wr[`CNT_W-1:0];
      end
    end
  end

  // write response
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      b_valid <= 1'b0;
    end
    else if (wr_take)
    begin
      b_valid <= 1'b1;
    end
    else if (b_ready)
    begin
      b_valid <= 1'b0;                                   // response taken
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_take)
    begin
      b_payload.resp <= wr_ok ? `RESP_OKAY : `RESP_SLVERR;
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb
  begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (rd_addr)
      `REG_ID0:       rd_data = `CL_ID0;
      `REG_ID1:       rd_data = `CL_ID1;
      `REG_STATUS0:   rd_data = `CL_STATUS0;
      `REG_VERSION:   rd_data = `CL_VERSION;
      `REG_CTRL:      rd_data = {{(`OCL_DATA_W-3){1'b0}}, cnt_ctrl.oneshot,
                                 cnt_ctrl.clear, cnt_ctrl.enable};
      `REG_TICK:      rd_data = {{(`OCL_DATA_W-`TICK_W){1'b0}}, cnt_ctrl.tick_value};
      `REG_LOAD:      rd_data = {{(`OCL_DATA_W-`CNT_W){1'b0}}, cnt_ctrl.load_value};
      `REG_WATERMARK: rd_data = {{(`OCL_DATA_W-`CNT_W){1'b0}}, cnt_ctrl.watermark};
      `REG_COUNT:     rd_data = {{(`OCL_DATA_W-`CNT_W){1'b0}}, cnt_stat.count};
      `REG_FLAGS:     rd_data = {{(`OCL_DATA_W-2){1'b0}}, cnt_stat.ge_watermark,
                                 cnt_stat.tick};
      default:        rd_err  = 1'b1;                    // unmapped, data stays 0
    endcase
  end

  // read response
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      r_valid <= 1'b0;
    end
    else if (rd_take)
    begin
      r_valid <= 1'b1;
    end
    else if (r_ready)
    begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_take)
    begin
      r_payload.data <= rd_data;                         // status sampled at take
      r_payload.resp <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
    end
  end

endmodule

/* hdl/tick_counter.sv */
`timescale 1ns/1ps

`include "cl_ocl_cfg.svh"

module tick_counter
  import cl_ocl_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n,
  input  cnt_ctrl_t cnt_ctrl,
  output cnt_stat_t cnt_stat
);

  logic [`TICK_W-1:0] tick_cnt;         // prescaler state
  logic [`CNT_W-1:0]  cnt;              // main count state
  logic               tick_wrap;        // prescaler at its period
  logic               cnt_max;

  // >= so a smaller period written mid count still wraps
  assign tick_wrap = (tick_cnt >= cnt_ctrl.tick_value);
  assign cnt_max   = (cnt == {`CNT_W{1'b1}});

  // ------------------------------
  // prescaler and main count
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n || cnt_ctrl.clear)
    begin
      tick_cnt <= '0;                   // clear has top priority
      cnt      <= '0;
    end
    else
    begin
      if (cnt_ctrl.enable)
      begin
        tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      end
      if (cnt_ctrl.load)
      begin
        cnt <= cnt_ctrl.load_value;     // load beats enable
      end
      else if (cnt_ctrl.enable && tick_wrap && !(cnt_ctrl.oneshot && cnt_max))
      begin
        cnt <= cnt + 1'b1;              // wraps unless oneshot holds at max
      end
    end
  end

  // status, one cycle behind the state
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt_stat <= '0;
    end
    else
    begin
      cnt_stat.count        <= cnt;
      cnt_stat.tick_cnt     <= tick_cnt;
      cnt_stat.tick         <= cnt_ctrl.enable & tick_wrap;
      cnt_stat.ge_watermark <= (cnt >= cnt_ctrl.watermark);
    end
  end

endmodule

/* hdl/cl_ocl_top.sv */
`timescale 1ns/1ps

module cl_ocl_top
  import cl_ocl_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n,

  // write address
  input  logic       aw_valid,
  output logic       aw_ready,
  input  ocl_addr_t  aw_payload,

  // write data
  input  logic       w_valid,
  output logic       w_ready,
  input  ocl_wdata_t w_payload,

  // write response
  output logic       b_valid,
  input  logic       b_ready,
  output ocl_bresp_t b_payload,

  // read address
  input  logic       ar_valid,
  output logic       ar_ready,
  input  ocl_addr_t  ar_payload,

  // read data
  output logic       r_valid,
  input  logic       r_ready,
  output ocl_rresp_t r_payload
);

  // registered request channels into the decoder
  logic       aw_q_valid;
  logic       aw_q_ready;
  ocl_addr_t  aw_q_payload;
  logic       w_q_valid;
  logic       w_q_ready;
  ocl_wdata_t w_q_payload;
  logic       ar_q_valid;
  logic       ar_q_ready;
  ocl_addr_t  ar_q_payload;

  cnt_ctrl_t  cnt_ctrl;                 // register file to counter
  cnt_stat_t  cnt_stat;                 // counter back to register file

  // ------------------------------
  // request slices
  // ------------------------------
  axil_reg_slice #(.payload_t(ocl_addr_t)) u_aw_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (aw_valid),
    .in_ready    (aw_ready),
    .in_payload  (aw_payload),
    .out_valid   (aw_q_valid),
    .out_ready   (aw_q_ready),
    .out_payload (aw_q_payload)
  );

  axil_reg_slice #(.payload_t(ocl_wdata_t)) u_w_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (w_valid),
    .in_ready    (w_ready),
    .in_payload  (w_payload),
    .out_valid   (w_q_valid),
    .out_ready   (w_q_ready),
    .out_payload (w_q_payload)
  );

  axil_reg_slice #(.payload_t(ocl_addr_t)) u_ar_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (ar_valid),
    .in_ready    (ar_ready),
    .in_payload  (ar_payload),
    .out_valid   (ar_q_valid),
    .out_ready   (ar_q_ready),
    .out_payload (ar_q_payload)
  );

  // ------------------------------
  // decoder and counter
  // ------------------------------
  ocl_reg_file u_reg_file (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .aw_valid    (aw_q_valid),
    .aw_ready    (aw_q_ready),
    .aw_payload  (aw_q_payload),
    .w_valid     (w_q_valid),
    .w_ready     (w_q_ready),
    .w_payload   (w_q_payload),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .b_payload   (b_payload),
    .ar_valid    (ar_q_valid),
    .ar_ready    (ar_q_ready),
    .ar_payload  (ar_q_payload),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_payload   (r_payload),
    .cnt_ctrl    (cnt_ctrl),
    .cnt_stat    (cnt_stat)
  );

  tick_counter u_counter (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cnt_ctrl    (cnt_ctrl),
    .cnt_stat    (cnt_stat)
  );

endmodule

/* dv/tb_cl_ocl.sv */
`timescale 1ns/1ps

module tb_cl_ocl
  import cl_ocl_pkg::*;
();

  localparam int CLK_HALF      = 5;           // 10 ns period
  localparam int STIM_MAX      = 64;          // stimulus lines held
  localparam int SETTLE        = 3;           // idle cycles after a waited transfer
  localparam int WDOG_PER_LINE = 200;         // watchdog budget per line

  localparam logic [3:0] OP_IDLE       = 4'h0;
  localparam logic [3:0] OP_WRITE      = 4'h1;
  localparam logic [3:0] OP_READ       = 4'h2;
  localparam logic [3:0] OP_WRITE_POST = 4'h3; // no wait for the response
  localparam logic [3:0] OP_READ_POST  = 4'h4;

  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] data;                        // write data or idle cycles
    logic [3:0]  strb;
    logic [3:0]  resp;
    logic [31:0] rdata;
  } stim_t;

  typedef struct packed {
    logic [31:0] addr;                        // for error lines only
    logic [31:0] data;
    logic [1:0]  resp;
  } exp_rsp_t;

  logic        clk_main_a0;
  logic        rst_main_n;
  logic        aw_valid;
  logic        aw_ready;
  ocl_addr_t   aw_payload;
  logic        w_valid;
  logic        w_ready;
  ocl_wdata_t  w_payload;
  logic        b_valid;
  logic        b_ready;
  ocl_bresp_t  b_payload;
  logic        ar_valid;
  logic        ar_ready;
  ocl_addr_t   ar_payload;
  logic        r_valid;
  logic        r_ready;
  ocl_rresp_t  r_payload;

  logic [107:0] stim_mem [STIM_MAX];          // raw lines from the data file
  int           n_stim;
  logic [31:0]  rng;
  exp_rsp_t     exp_b_q[$];                   // in order, oldest first
  exp_rsp_t     exp_r_q[$];

  cl_ocl_top UUT (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .aw_payload  (aw_payload),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .w_payload   (w_payload),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .b_payload   (b_payload),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar_payload  (ar_payload),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_payload   (r_payload)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int count_stim_lines();
    int n;
    n = 0;
    while (n < STIM_MAX && !$isunknown(stim_mem[n][107:104]))
      n++;                                    // lines end at the first unloaded word
    return n;
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic next_cycle();
    @(posedge clk_main_a0);
    #1;                                       // drive 1 ns after the edge
  endtask

  task automatic drain();
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0)
      next_cycle();
  endtask

  task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic aw_hs;
    logic w_hs;
    aw_payload.addr = addr;
    w_payload.data  = data;
    w_payload.strb  = strb;
    aw_valid        = 1'b1;
    w_valid         = 1'b1;
    while (aw_valid || w_valid)
    begin
      @(negedge clk_main_a0);                 // mid cycle, all stable
      aw_hs = aw_valid && aw_ready;
      w_hs  = w_valid && w_ready;
      next_cycle();
      if (aw_hs)
        aw_valid = 1'b0;
      if (w_hs)
        w_valid = 1'b0;
    end
  endtask

  task automatic issue_read(input logic [31:0] addr);
    logic ar_hs;
    ar_payload.addr = addr;
    ar_valid        = 1'b1;
    while (ar_valid)
    begin
      @(negedge clk_main_a0);
      ar_hs = ar_valid && ar_ready;
      next_cycle();
      if (ar_hs)
        ar_valid = 1'b0;
    end
  endtask

  task automatic run_line(input stim_t s);
    exp_rsp_t e;
    e.addr = s.addr;
    e.data = s.rdata;
    e.resp = s.resp[1:0];
    case (s.op)
      OP_IDLE:
      begin
        drain();                              // idle starts from an empty bus
        repeat (s.data) next_cycle();
      end
      OP_WRITE, OP_WRITE_POST:
      begin
        exp_b_q.push_back(e);
        issue_write(s.addr, s.data, s.strb);
      end
      OP_READ, OP_READ_POST:
      begin
        exp_r_q.push_back(e);
        issue_read(s.addr);
      end
      default:
        stop_with_error($sformatf("stimulus line has unknown operation %0h", s.op));
    endcase
    if (s.op == OP_WRITE || s.op == OP_READ)
    begin
      drain();
      repeat (SETTLE) next_cycle();           // control to counter to status lag
    end
  endtask

  task automatic check_write_resp();
    exp_rsp_t e;
    assert (exp_b_q.size() > 0)
    else stop_with_error("write response arrived with no write outstanding");
    e = exp_b_q.pop_front();
    assert (b_payload.resp == e.resp)
    else stop_with_error($sformatf("FAIL %0t ns: write 0x%08h resp %0d, expected %0d",
                                   $time, e.addr, b_payload.resp, e.resp));
  endtask

  task automatic check_read_resp();
    exp_rsp_t e;
    assert (exp_r_q.size() > 0)
    else stop_with_error("read response arrived with no read outstanding");
    e = exp_r_q.pop_front();
    assert (r_payload.resp == e.resp && r_payload.data == e.data)
    else stop_with_error($sformatf(
      "FAIL %0t ns: read 0x%08h got 0x%08h resp %0d, expected 0x%08h resp %0d",
      $time, e.addr, r_payload.data, r_payload.resp, e.data, e.resp));
  endtask

  // ------------------------------
  // clock, ready, monitors
  // ------------------------------
  initial
  begin
    clk_main_a0 = 1'b0;
    forever #CLK_HALF clk_main_a0 = ~clk_main_a0;
  end

  initial
  begin
    rng     = 32'h4c3f;
    b_ready = 1'b0;
    r_ready = 1'b0;
    wait (rst_main_n === 1'b1);
    forever
    begin
      next_cycle();
      rng     = xorshift32(rng);
      b_ready = (rng[1:0] != 2'b00);          // high about 3 cycles in 4
      r_ready = (rng[5:4] != 2'b00);
    end
  end

  // handshake seen mid cycle is the one taken at the next edge
  always @(negedge clk_main_a0)
  begin
    if (rst_main_n && b_valid && b_ready)
      check_write_resp();
    if (rst_main_n && r_valid && r_ready)
      check_read_resp();
  end

  initial
  begin
    wait (n_stim > 0);
    repeat (n_stim * WDOG_PER_LINE) @(posedge clk_main_a0);
    stop_with_error($sformatf("timeout, run did not finish within %0d cycles",
                              n_stim * WDOG_PER_LINE));
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    n_stim     = 0;
    rst_main_n = 1'b0;
    aw_valid   = 1'b0;
    aw_payload = '0;
    w_valid    = 1'b0;
    w_payload  = '0;
    ar_valid   = 1'b0;
    ar_payload = '0;
    $readmemh("dv/ocl_stimulus.txt", stim_mem);
    n_stim = count_stim_lines();
    if (n_stim == 0)
      stop_with_error("stimulus file dv/ocl_stimulus.txt is missing or empty");
    repeat (3) @(posedge clk_main_a0);        // reset held 3 cycles
    #1;
    rst_main_n = 1'b1;
    next_cycle();
    for (int i = 0; i < n_stim; i++)
      run_line(stim_mem[i]);
    drain();                                  // every response seen once
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/cl_ocl_pkg.sv
hdl/axil_reg_slice.sv
hdl/ocl_reg_file.sv
hdl/tick_counter.sv
hdl/cl_ocl_top.sv
dv/tb_cl_ocl.sv

/* dv/ocl_stimulus.txt */
// columns, all hex: op _ offset _ data _ strobe _ expected resp _ expected read data
// op 0 idle (data = cycles), 1 write, 2 read, 3 write back to back, 4 read back to back
// identity and status words
2_00000000_00000000_0_0_A1C07E55
2_00000004_00000000_0_0_00010F00
2_00000008_00000000_0_0_00000FF0
2_0000000C_00000000_0_0_EEEEEE00
// error responses and byte strobes
1_00000020_00000001_F_2_00000000
2_00000040_00000000_0_2_00000000
1_00000040_DEADBEEF_F_2_00000000
1_0000001C_00001234_F_0_00000000
1_0000001C_000055AA_1_0_00000000
2_0000001C_00000000_0_0_000012AA
// load while disabled
1_00000018_00001234_F_0_00000000
2_00000020_00000000_0_0_00001234
0_00000000_00000010_0_0_00000000
2_00000020_00000000_0_0_00001234
// watermark flag, then clear
1_0000001C_00001000_F_0_00000000
2_00000024_00000000_0_0_00000002
1_0000001C_00002000_F_0_00000000
2_00000024_00000000_0_0_00000000
1_00000010_00000002_F_0_00000000
2_00000020_00000000_0_0_00000000
// one-shot saturation
1_00000010_00000000_F_0_00000000
1_00000018_0000FFF0_F_0_00000000
1_00000014_00000000_F_0_00000000
1_00000010_00000005_F_0_00000000
0_00000000_00000064_0_0_00000000
1_00000010_00000000_F_0_00000000
2_00000020_00000000_0_0_0000FFFF
// back to back under back-pressure
3_00000014_000000A5_F_0_00000000
4_00000000_00000000_0_0_A1C07E55
3_00000040_12345678_F_2_00000000
4_00000020_00000000_0_0_0000FFFF
3_0000001C_00003000_F_0_00000000
4_00000044_00000000_0_2_00000000
3_00000024_00000003_F_2_00000000
4_0000000C_00000000_0_0_EEEEEE00
3_00000014_0000005A_F_0_00000000
4_00000018_00000000_0_0_0000FFF0
0_00000000_00000008_0_0_00000000
2_00000014_00000000_0_0_0000005A
